// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // widths
    localparam int len_word     = 32;
    localparam int len_inst     = 32;
    localparam int len_reg_addr = 6;   // bit 5 selects the float bank
    localparam int len_opcode   = 7;
    localparam int len_func3    = 3;
    localparam int len_func7    = 7;
    localparam int num_regs     = 64;

    typedef logic [len_word-1:0]     word_t;
    typedef logic [len_inst-1:0]     inst_t;
    typedef logic [len_reg_addr-1:0] reg_addr_t;
    typedef logic [len_opcode-1:0]   opcode_t;
    typedef logic [len_func3-1:0]    func3_t;
    typedef logic [len_func7-1:0]    func7_t;

    // integer unit
    localparam opcode_t op_alu    = 7'b0110011;
    localparam opcode_t op_alui   = 7'b0010011;

    // upper immediate
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;

    // control transfer
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;

    // loads and stores, integer then float
    localparam opcode_t op_meml   = 7'b0000011;
    localparam opcode_t op_mems   = 7'b0100011;
    localparam opcode_t op_fmeml  = 7'b0000111;
    localparam opcode_t op_fmems  = 7'b0100111;

    localparam opcode_t op_fpu    = 7'b1010011;

    // custom io opcodes
    localparam opcode_t op_input  = 7'b0001011;
    localparam opcode_t op_output = 7'b0101011;

endpackage

// ==== src/decode.sv ====
`timescale 1ns/10ps

module decode (
    input  cpu_pkg::inst_t     instr,
    input  cpu_pkg::word_t     pc,

    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t     rs1_data,
    input  cpu_pkg::word_t     rs2_data,

    output logic               alu,
    output logic               alu_imm,
    output logic               alu_ext,
    output logic               fpu,
    output logic               mem,
    output logic               jump,
    output logic               branch,
    output logic               subst,
    output logic               io,

    output cpu_pkg::word_t     d_rs1,
    output cpu_pkg::word_t     d_rs2,
    output cpu_pkg::word_t     d_rs3,
    output cpu_pkg::reg_addr_t a_rd,

    output cpu_pkg::opcode_t   opcode,
    output cpu_pkg::func3_t    func3,
    output cpu_pkg::func7_t    func7
);
    import cpu_pkg::*;

    logic  float_op;
    logic  rs1_float;
    logic  rs2_float;
    logic  rd_float;
    logic  no_use_rd;
    logic  no_use_rs1;
    logic  no_use_rs2;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;

    // raw fields
    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];

    // unit classification
    assign alu    = (opcode == op_alu) | (opcode == op_alui);
    assign fpu    = (opcode == op_fpu);
    assign mem    = (opcode == op_meml)  | (opcode == op_mems)
                  | (opcode == op_fmeml) | (opcode == op_fmems);
    assign jump   = (opcode == op_jal) | (opcode == op_jalr);
    assign branch = (opcode == op_branch);
    assign subst  = (opcode == op_lui) | (opcode == op_auipc);
    assign io     = (opcode == op_input) | (opcode == op_output);

    assign alu_imm = (opcode == op_alui);
    assign alu_ext = (opcode == op_alu) & func7[0];  // mul/div group

    // float bank selection
    assign float_op = fpu
                    | (opcode == op_fmeml)
                    | (opcode == op_fmems)
                    | (io & func7[5]);

    // compare/convert ops move between banks, func7[6] with func7[4:3]
    assign rs1_float = float_op & ~mem
                     & (~func7[6] | (func7[3] ^ func7[4]) | io);
    assign rs2_float = float_op;
    assign rd_float  = float_op
                     & (~func7[6] | ~(func7[3] ^ func7[4]) | io);

    // operands that the opcode does not read or write
    assign no_use_rd  = (opcode == op_mems)
                      | (opcode == op_fmems)
                      | (opcode == op_output)
                      | (opcode == op_branch);
    assign no_use_rs1 = (opcode == op_lui)
                      | (opcode == op_auipc)
                      | (opcode == op_jal)
                      | (opcode == op_input);
    assign no_use_rs2 = ~((opcode == op_alu)
                      | (opcode == op_branch)
                      | (opcode == op_mems)
                      | (opcode == op_fmems)
                      | (fpu & ~func7[5]));  // single-source fpu ops

    assign a_rd     = no_use_rd  ? '0 : {rd_float, instr[11:7]};
    assign rs1_addr = no_use_rs1 ? '0 : {rs1_float, instr[19:15]};
    assign rs2_addr = no_use_rs2 ? '0 : {rs2_float, instr[24:20]};

    // sign extended immediates
    assign imm_i = {{(len_word-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(len_word-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(len_word-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(len_word-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // address sum or jump target
    always_comb begin
        case (opcode)
            op_meml,
            op_fmeml,
            op_jalr:  d_rs1 = rs1_data + imm_i;
            op_mems,
            op_fmems: d_rs1 = rs1_data + imm_s;
            op_jal:   d_rs1 = pc + imm_j;
            default:  d_rs1 = rs1_data;
        endcase
    end

    assign d_rs2 = alu_imm ? imm_i : rs2_data;

    // immediate or pc relative target
    always_comb begin
        case (opcode)
            op_mems,
            op_fmems:  d_rs3 = imm_s;
            op_branch: d_rs3 = pc + imm_b;
            op_jal:    d_rs3 = pc + imm_j;
            op_lui:    d_rs3 = imm_u;
            op_auipc:  d_rs3 = pc + imm_u;
            default:   d_rs3 = imm_i;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n,

    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,

    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t regs [num_regs];
    logic  wr_ok;

    // x0 is not writable, f0 at 32 is
    assign wr_ok = wb_en & (wb_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write-first reads
    assign rs1_data = (rs1_addr == '0)                     ? '0 :
                      (wr_ok && (wb_addr == rs1_addr))     ? wb_data :
                                                             regs[rs1_addr];

    assign rs2_data = (rs2_addr == '0)                     ? '0 :
                      (wr_ok && (wb_addr == rs2_addr))     ? wb_data :
                                                             regs[rs2_addr];

endmodule

// ==== src/issue_reg.sv ====
`timescale 1ns/10ps

module issue_reg (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load,
    input  logic               stall,
    input  logic               flush,

    input  logic               alu,
    input  logic               alu_imm,
    input  logic               alu_ext,
    input  logic               fpu,
    input  logic               mem,
    input  logic               jump,
    input  logic               branch,
    input  logic               subst,
    input  logic               io,
    input  cpu_pkg::reg_addr_t a_rd,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t     d_rs1,
    input  cpu_pkg::word_t     d_rs2,
    input  cpu_pkg::word_t     d_rs3,
    input  cpu_pkg::opcode_t   opcode,
    input  cpu_pkg::func3_t    func3,
    input  cpu_pkg::func7_t    func7,

    output logic               iss_valid,
    output logic               iss_alu,
    output logic               iss_alu_imm,
    output logic               iss_alu_ext,
    output logic               iss_fpu,
    output logic               iss_mem,
    output logic               iss_jump,
    output logic               iss_branch,
    output logic               iss_subst,
    output logic               iss_io,
    output cpu_pkg::reg_addr_t iss_a_rd,
    output cpu_pkg::reg_addr_t iss_rs1_addr,
    output cpu_pkg::reg_addr_t iss_rs2_addr,
    output cpu_pkg::word_t     iss_d_rs1,
    output cpu_pkg::word_t     iss_d_rs2,
    output cpu_pkg::word_t     iss_d_rs3,
    output cpu_pkg::opcode_t   iss_opcode,
    output cpu_pkg::func3_t    iss_func3,
    output cpu_pkg::func7_t    iss_func7
);

    logic capture;

    assign capture = load & ~stall & ~flush;  // flush wins

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
        end else if (flush) begin
            iss_valid <= 1'b0;
        end else if (!stall) begin
            iss_valid <= load;  // bubble when nothing arrives
        end
    end

    // bundle held while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            {iss_alu, iss_alu_imm, iss_alu_ext, iss_fpu, iss_mem} <= '0;
            {iss_jump, iss_branch, iss_subst, iss_io}             <= '0;
            {iss_a_rd, iss_rs1_addr, iss_rs2_addr}                <= '0;
            {iss_d_rs1, iss_d_rs2, iss_d_rs3}                     <= '0;
            {iss_opcode, iss_func3, iss_func7}                    <= '0;
        end else if (capture) begin
            {iss_alu, iss_alu_imm, iss_alu_ext, iss_fpu, iss_mem} <= {alu, alu_imm, alu_ext, fpu, mem};
            {iss_jump, iss_branch, iss_subst, iss_io}             <= {jump, branch, subst, io};
            {iss_a_rd, iss_rs1_addr, iss_rs2_addr}                <= {a_rd, rs1_addr, rs2_addr};
            {iss_d_rs1, iss_d_rs2, iss_d_rs3}                     <= {d_rs1, d_rs2, d_rs3};
            {iss_opcode, iss_func3, iss_func7}                    <= {opcode, func3, func7};
        end
    end

endmodule

// ==== src/issue_unit.sv ====
`timescale 1ns/10ps

module issue_unit (
    input  logic               clk,
    input  logic               arst_n,

    input  logic               instr_valid,
    input  cpu_pkg::inst_t     instr,
    input  cpu_pkg::word_t     pc,
    input  logic               stall,
    input  logic               flush,

    input  logic               wb_en,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,

    output logic               iss_valid,
    output logic               iss_alu,
    output logic               iss_alu_imm,
    output logic               iss_alu_ext,
    output logic               iss_fpu,
    output logic               iss_mem,
    output logic               iss_jump,
    output logic               iss_branch,
    output logic               iss_subst,
    output logic               iss_io,
    output cpu_pkg::reg_addr_t iss_a_rd,
    output cpu_pkg::reg_addr_t iss_rs1_addr,
    output cpu_pkg::reg_addr_t iss_rs2_addr,
    output cpu_pkg::word_t     iss_d_rs1,
    output cpu_pkg::word_t     iss_d_rs2,
    output cpu_pkg::word_t     iss_d_rs3,
    output cpu_pkg::opcode_t   iss_opcode,
    output cpu_pkg::func3_t    iss_func3,
    output cpu_pkg::func7_t    iss_func7
);
    import cpu_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t a_rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     d_rs1;
    word_t     d_rs2;
    word_t     d_rs3;
    opcode_t   opcode;
    func3_t    func3;
    func7_t    func7;
    logic      alu;
    logic      alu_imm;
    logic      alu_ext;
    logic      fpu;
    logic      mem;
    logic      jump;
    logic      branch;
    logic      subst;
    logic      io;

    decode decode_i (
        .instr, .pc,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .alu, .alu_imm, .alu_ext, .fpu, .mem, .jump, .branch, .subst, .io,
        .d_rs1, .d_rs2, .d_rs3, .a_rd,
        .opcode, .func3, .func7
    );

    // writeback comes straight from outside
    reg_file reg_file_i (
        .clk, .arst_n,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wb_en, .wb_addr, .wb_data
    );

    issue_reg issue_reg_i (
        .clk, .arst_n,
        .load (instr_valid),
        .stall, .flush,
        .alu, .alu_imm, .alu_ext, .fpu, .mem, .jump, .branch, .subst, .io,
        .a_rd, .rs1_addr, .rs2_addr, .d_rs1, .d_rs2, .d_rs3,
        .opcode, .func3, .func7,
        .iss_valid,
        .iss_alu, .iss_alu_imm, .iss_alu_ext, .iss_fpu, .iss_mem,
        .iss_jump, .iss_branch, .iss_subst, .iss_io,
        .iss_a_rd, .iss_rs1_addr, .iss_rs2_addr,
        .iss_d_rs1, .iss_d_rs2, .iss_d_rs3,
        .iss_opcode, .iss_func3, .iss_func7
    );

endmodule

// ==== verification/issue_unit_tb.sv ====
`timescale 1ns/10ps

module issue_unit_tb;
    import cpu_pkg::*;

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    inst_t     instr;
    word_t     pc;
    logic      stall;
    logic      flush;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    logic      iss_valid;
    logic      iss_alu;
    logic      iss_alu_imm;
    logic      iss_alu_ext;
    logic      iss_fpu;
    logic      iss_mem;
    logic      iss_jump;
    logic      iss_branch;
    logic      iss_subst;
    logic      iss_io;
    reg_addr_t iss_a_rd;
    reg_addr_t iss_rs1_addr;
    reg_addr_t iss_rs2_addr;
    word_t     iss_d_rs1;
    word_t     iss_d_rs2;
    word_t     iss_d_rs3;
    opcode_t   iss_opcode;
    func3_t    iss_func3;
    func7_t    iss_func7;

    int unsigned rng_state    = 68;
    int          cycles       = 0;
    int          cycle_limit  = 10000;  // reset once the table is known
    int          test_errors  = 0;
    int          total_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    word_t       shadow [num_regs];     // expected register file contents
    inst_t       tab_instr [$];
    word_t       tab_pc [$];
    string       tab_name [$];
    string       flag_names [9] = '{"iss_alu", "iss_alu_imm", "iss_alu_ext", "iss_fpu",
                                    "iss_mem", "iss_jump", "iss_branch", "iss_subst", "iss_io"};

    issue_unit issue_unit_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state ^ (rng_state >> 15);
    endfunction

    function automatic inst_t enc(func7_t f7, logic [4:0] rs2, logic [4:0] rs1, func3_t f3,
                                  logic [4:0] rd, opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [8:0] iss_flags();
        return {iss_alu, iss_alu_imm, iss_alu_ext, iss_fpu, iss_mem,
                iss_jump, iss_branch, iss_subst, iss_io};
    endfunction

    // alu, alu_imm, alu_ext, fpu, mem, jump, branch, subst, io
    function automatic logic [8:0] ref_flags(inst_t i);
        logic [8:0] f;
        case (i[6:0])
            op_alu:                                f = {1'b1, 1'b0, i[25], 6'b0};
            op_alui:                               f = 9'b110_000_000;
            op_fpu:                                f = 9'b000_100_000;
            op_meml, op_mems, op_fmeml, op_fmems:  f = 9'b000_010_000;
            op_jal, op_jalr:                       f = 9'b000_001_000;
            op_branch:                             f = 9'b000_000_100;
            op_lui, op_auipc:                      f = 9'b000_000_010;
            op_input, op_output:                   f = 9'b000_000_001;
            default:                               f = '0;
        endcase
        return f;
    endfunction

    task automatic ref_addrs(input inst_t i, output reg_addr_t rd, output reg_addr_t rs1,
                             output reg_addr_t rs2);
        opcode_t op;
        func7_t  f7;
        logic    fl;
        logic    mem_op;
        logic    io_op;
        logic    rd_fl;
        logic    rs1_fl;
        logic    rs2_used;
        op     = i[6:0];
        f7     = i[31:25];
        mem_op = op inside {op_meml, op_mems, op_fmeml, op_fmems};
        io_op  = op inside {op_input, op_output};
        fl     = (op == op_fpu) || (op == op_fmeml) || (op == op_fmems) || (io_op && f7[5]);
        if (!fl) begin
            rd_fl  = 1'b0;
            rs1_fl = 1'b0;
        end else if (io_op || !f7[6]) begin
            rd_fl  = 1'b1;
            rs1_fl = !mem_op;   // memory address stays integer
        end else begin
            // for compare or convert f7[4] against f7[3] picks the float side
            rd_fl  = (f7[4] == f7[3]);
            rs1_fl = !mem_op && (f7[4] != f7[3]);
        end
        rs2_used = (op == op_alu) || (op == op_branch) || (op == op_mems)
                   || (op == op_fmems) || ((op == op_fpu) && !f7[5]);
        rd  = (op inside {op_mems, op_fmems, op_output, op_branch}) ? '0 : {rd_fl, i[11:7]};
        rs1 = (op inside {op_lui, op_auipc, op_jal, op_input}) ? '0 : {rs1_fl, i[19:15]};
        rs2 = rs2_used ? {fl, i[24:20]} : '0;
    endtask

    task automatic ref_operands(input inst_t i, input word_t p, input word_t v1,
                                input word_t v2, output word_t d1, output word_t d2,
                                output word_t d3);
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        word_t imm_u;
        imm_i = $signed(i) >>> 20;
        imm_s = {imm_i[31:5], i[11:7]};
        imm_b = {imm_s[31:12], i[7], imm_s[10:1], 1'b0};
        imm_j = {imm_i[31:20], i[19:12], i[20], i[30:21], 1'b0};
        imm_u = {i[31:12], 12'h000};
        case (i[6:0])
            op_meml, op_fmeml, op_jalr: d1 = v1 + imm_i;
            op_mems, op_fmems:          d1 = v1 + imm_s;
            op_jal:                     d1 = p + imm_j;
            default:                    d1 = v1;
        endcase
        d2 = (i[6:0] == op_alui) ? imm_i : v2;
        case (i[6:0])
            op_mems, op_fmems: d3 = imm_s;
            op_branch:         d3 = p + imm_b;
            op_jal:            d3 = p + imm_j;
            op_lui:            d3 = imm_u;
            op_auipc:          d3 = p + imm_u;
            default:           d3 = imm_i;
        endcase
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flags(logic [8:0] exp);
        logic [8:0] act;
        act = iss_flags();
        for (int k = 0; k < 9; k++) begin
            check_flag(flag_names[k], exp[8-k], act[8-k]);
        end
    endtask

    // full issued bundle against the reference model
    task automatic check_issue(inst_t i, word_t p);
        reg_addr_t e_rd;
        reg_addr_t e_rs1;
        reg_addr_t e_rs2;
        word_t     e_d1;
        word_t     e_d2;
        word_t     e_d3;
        ref_addrs(i, e_rd, e_rs1, e_rs2);
        ref_operands(i, p, shadow[e_rs1], shadow[e_rs2], e_d1, e_d2, e_d3);
        check_flag("iss_valid", 1'b1, iss_valid);
        check_flags(ref_flags(i));
        check_addr("iss_a_rd", e_rd, iss_a_rd);
        check_addr("iss_rs1_addr", e_rs1, iss_rs1_addr);
        check_addr("iss_rs2_addr", e_rs2, iss_rs2_addr);
        check_word("iss_d_rs1", e_d1, iss_d_rs1);
        check_word("iss_d_rs2", e_d2, iss_d_rs2);
        check_word("iss_d_rs3", e_d3, iss_d_rs3);
        check_word("iss_opcode", word_t'(i[6:0]), word_t'(iss_opcode));
        check_word("iss_func3", word_t'(i[14:12]), word_t'(iss_func3));
        check_word("iss_func7", word_t'(i[31:25]), word_t'(iss_func7));
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
        test_errors = 0;
    endtask

    task automatic add_entry(string name, inst_t i);
        tab_name.push_back(name);
        tab_instr.push_back(i);
        tab_pc.push_back(lcg_next() & 32'hffff_fffc);
    endtask

    task automatic build_table();
        opcode_t ops [14];
        ops = '{op_alu, op_alui, op_lui, op_auipc, op_jal, op_jalr, op_branch,
                op_meml, op_mems, op_fmeml, op_fmems, op_fpu, op_input, op_output};
        // both read ports over every register including f0
        for (int k = 0; k < 32; k++) begin
            add_entry("readback int", enc(7'h00, 5'(31 - k), 5'(k), 3'd0, 5'd5, op_alu));
            add_entry("readback float", enc(7'h00, 5'(31 - k), 5'(k), 3'd0, 5'd6, op_fpu));
        end
        foreach (ops[k]) begin
            add_entry("class", enc(7'h01, 5'd3, 5'd4, 3'd2, 5'd6, ops[k]));
        end
        add_entry("addr fpu int->float", enc(7'h60, 5'd7, 5'd4, 3'd0, 5'd5, op_fpu));
        add_entry("addr fpu float->int", enc(7'h68, 5'd7, 5'd4, 3'd0, 5'd5, op_fpu));
        add_entry("addr fpu compare", enc(7'h50, 5'd8, 5'd9, 3'd1, 5'd10, op_fpu));
        add_entry("addr input float", enc(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, op_input));
        add_entry("addr output float", enc(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, op_output));
        add_entry("addr input", enc(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, op_input));
        add_entry("addr output", enc(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, op_output));
        add_entry("imm load", enc(7'h7f, 5'h18, 5'd7, 3'd2, 5'd10, op_meml));
        add_entry("imm float load", enc(7'h7e, 5'h04, 5'd8, 3'd2, 5'd11, op_fmeml));
        add_entry("imm store", enc(7'h7f, 5'd12, 5'd13, 3'd2, 5'h14, op_mems));
        add_entry("imm float store", enc(7'h40, 5'd3, 5'd14, 3'd2, 5'd0, op_fmems));
        add_entry("imm jal", enc(7'h7f, 5'h1e, 5'h1f, 3'h7, 5'd1, op_jal));
        add_entry("imm jalr", enc(7'h7f, 5'h10, 5'd15, 3'd0, 5'd1, op_jalr));
        add_entry("imm branch", enc(7'h7e, 5'd16, 5'd17, 3'd1, 5'h19, op_branch));
        add_entry("imm lui", enc(7'h55, 5'h0a, 5'd3, 3'd5, 5'd18, op_lui));
        add_entry("imm auipc", enc(7'h7f, 5'h1f, 5'h1f, 3'h7, 5'd19, op_auipc));
        add_entry("imm alui neg", enc(7'h7f, 5'h1b, 5'd20, 3'd0, 5'd21, op_alui));
        add_entry("imm alui pos", enc(7'h12, 5'h05, 5'd22, 3'd0, 5'd23, op_alui));
    endtask

    // one instruction, with an optional writeback in the same cycle
    task automatic issue(inst_t i, word_t p, logic wr, reg_addr_t wa, word_t wd);
        @(posedge clk);
        instr       <= i;
        pc          <= p;
        instr_valid <= 1'b1;
        wb_en       <= wr;
        wb_addr     <= wa;
        wb_data     <= wd;
        @(posedge clk);
        instr_valid <= 1'b0;
        wb_en       <= 1'b0;
        @(negedge clk);
    endtask

    initial begin
        word_t v;
        word_t p;
        inst_t ins;

        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        for (int a = 0; a < num_regs; a++) begin
            shadow[a] = '0;
        end
        build_table();
        cycle_limit = 64 + 4 * (tab_instr.size() + 64);

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("iss_valid", 1'b0, iss_valid);
        check_flags('0);
        check_addr("iss_a_rd", '0, iss_a_rd);
        check_addr("iss_rs1_addr", '0, iss_rs1_addr);
        check_addr("iss_rs2_addr", '0, iss_rs2_addr);
        check_word("iss_d_rs1", '0, iss_d_rs1);
        check_word("iss_d_rs2", '0, iss_d_rs2);
        check_word("iss_d_rs3", '0, iss_d_rs3);
        check_word("iss_opcode", '0, word_t'(iss_opcode));
        check_word("iss_func3", '0, word_t'(iss_func3));
        check_word("iss_func7", '0, word_t'(iss_func7));
        end_test("reset");

        for (int a = 0; a < num_regs; a++) begin
            v = lcg_next();
            @(posedge clk);
            wb_en   <= 1'b1;
            wb_addr <= reg_addr_t'(a);
            wb_data <= v;
            if (a != 0) begin
                shadow[a] = v;  // x0 write dropped
            end
        end
        @(posedge clk);
        wb_en <= 1'b0;

        for (int n = 0; n < tab_instr.size(); n++) begin
            issue(tab_instr[n], tab_pc[n], 1'b0, '0, '0);
            check_issue(tab_instr[n], tab_pc[n]);
            end_test(tab_name[n]);
        end

        // same-cycle writeback to rs1, then a plain later read
        v   = lcg_next();
        p   = lcg_next();
        ins = enc(7'h00, 5'd2, 5'd9, 3'd0, 5'd3, op_alu);
        shadow[9] = v;
        issue(ins, p, 1'b1, 6'd9, v);
        check_issue(ins, p);
        issue(ins, p, 1'b0, '0, '0);
        check_issue(ins, p);
        end_test("forward");
        ins = enc(7'h00, 5'd2, 5'd0, 3'd0, 5'd3, op_alu);
        issue(ins, p, 1'b1, '0, lcg_next());
        check_issue(ins, p);
        end_test("forward x0");

        ins = enc(7'h00, 5'd21, 5'd20, 3'd4, 5'd22, op_alu);
        @(posedge clk);
        instr       <= ins;
        pc          <= p;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b1;   // lands right after the capture edge
        instr       <= enc(7'h01, 5'd5, 5'd6, 3'd1, 5'd7, op_mems);
        pc          <= ~p;     // decoder input moves while the bundle holds
        repeat (4) begin
            @(negedge clk);
            check_issue(ins, p);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_issue(ins, p);
        @(negedge clk);
        check_flag("iss_valid", 1'b0, iss_valid);
        end_test("stall");

        // flush beats a capture in the same cycle
        @(posedge clk);
        instr       <= ins;
        pc          <= p;
        instr_valid <= 1'b1;
        flush       <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        flush       <= 1'b0;
        @(negedge clk);
        check_flag("iss_valid", 1'b0, iss_valid);
        end_test("flush");

        @(posedge clk);
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b1;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b0;
        @(negedge clk);
        check_flag("iss_valid", 1'b0, iss_valid);
        end_test("flush in stall");

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
                 total_errors);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/cpu_pkg.sv
src/decode.sv
src/reg_file.sv
src/issue_reg.sv
src/issue_unit.sv
verification/issue_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the issue_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module issue_unit_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vissue_unit_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
exit 0
